// File: filelist.f
+incdir+include
source/conv_pe_pkg.sv
source/window_if.sv
source/conv_pe_ctrl.sv
source/line_buffer.sv
source/window_select.sv
source/conv_mac_array.sv
source/conv_pe_top.sv
test/conv_pe_properties.sv
test/conv_pe_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module conv_pe_tb -o conv_pe_sim \
	-f filelist.f

./obj_dir/conv_pe_sim 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: test/conv_pe_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_pe_params.svh"

module conv_pe_tb
	import conv_pe_pkg::*;
();

	localparam int N_ENTRIES = 11;

	logic clk = 1'b0;
	logic rst_n;
	logic row_valid;
	row_t row_data;
	kernel_t kernel0;
	kernel_t kernel1;
	kernel_t kernel2;
	logic busy;
	logic out_valid;
	col_t out_col;
	acc_t result0;
	acc_t result1;
	acc_t result2;

	// one entry per row strobe
	row_t tab_row [N_ENTRIES];
	kernel_t tab_kern [N_ENTRIES][`N_KERNELS];
	bit tab_sweep [N_ENTRIES];
	bit tab_intrude [N_ENTRIES];

	// last three accepted rows, oldest first
	row_t model_rows [`K_SIZE];
	longint exp_sum [N_ENTRIES][`N_COLS][`N_KERNELS];
	int pending_q [$];
	int mon_col = 0;
	int cyc = 0;
	int busy_rise = 0;
	int sweep_err_start = 0;
	int errors = 0;
	int checks = 0;
	logic busy_prev = 1'b0;
	bit timeout_hit = 1'b0;

	conv_pe_top UUT (.*);

	bind conv_pe_top conv_pe_properties u_props (.*);

	always #2 clk = ~clk;

	function automatic row_t random_row();
		row_t r;
		for (int j = 0; j < `ROW_LEN; j++) begin
			r[j] = pixel_t'($urandom());
		end
		return r;
	endfunction

	function automatic kernel_t random_kernel();
		kernel_t w;
		for (int j = 0; j < `K_SIZE * `K_SIZE; j++) begin
			w[j] = weight_t'($urandom());
		end
		return w;
	endfunction

	// full-precision sum over the window at column c
	function automatic longint ref_sum(int c, kernel_t kern);
		longint acc;
		pixel_t px;
		weight_t w;
		acc = '0;
		for (int r = 0; r < `K_SIZE; r++) begin
			for (int k = 0; k < `K_SIZE; k++) begin
				px = model_rows[r][c + k];
				w = kern[r * `K_SIZE + k];
				acc = acc + longint'(px) * longint'(w);
			end
		end
		return acc;
	endfunction

	task automatic check_value(string name, longint expv, longint gotv);
		checks++;
		if (gotv != expv) begin
			$display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expv, gotv);
			errors++;
		end
	endtask

	task automatic build_table();
		pixel_t ext;
		for (int i = 0; i < N_ENTRIES; i++) begin
			tab_row[i] = random_row();
			for (int n = 0; n < `N_KERNELS; n++) begin
				tab_kern[i][n] = random_kernel();
			end
			tab_sweep[i] = (i >= 2);
			tab_intrude[i] = (i == 4);
		end
		// center tap and its negation, third kernel stays random
		tab_kern[3][0] = '0;
		tab_kern[3][0][4] = weight_t'(1);
		tab_kern[3][1] = '0;
		tab_kern[3][1][4] = weight_t'(-1);
		// three rows at the negative end, then three at the positive end
		for (int i = 5; i < N_ENTRIES; i++) begin
			ext = (i < 8) ? pixel_t'(-256) : pixel_t'(255);
			tab_row[i] = {`ROW_LEN{ext}};
			for (int n = 0; n < `N_KERNELS; n++) begin
				tab_kern[i][n] = {(`K_SIZE * `K_SIZE){ext}};
			end
		end
	endtask

	task automatic wait_busy_low();
		for (int n = 0; n < 100; n++) begin
			@(negedge clk);
			if (!busy) begin
				return;
			end
		end
		$display("timeout: busy stayed high for 100 cycles");
		timeout_hit = 1'b1;
	endtask

	task automatic apply_entry(int i);
		int err_start;
		err_start = errors;
		wait_busy_low();
		if (timeout_hit) begin
			return;
		end
		row_data = tab_row[i];
		row_valid = 1'b1;
		model_rows[0] = model_rows[1];
		model_rows[1] = model_rows[2];
		model_rows[2] = tab_row[i];
		if (tab_sweep[i]) begin
			for (int c = 0; c < `N_COLS; c++) begin
				for (int n = 0; n < `N_KERNELS; n++) begin
					exp_sum[i][c][n] = ref_sum(c, tab_kern[i][n]);
				end
			end
			pending_q.push_back(i);
		end
		@(negedge clk);
		row_valid = 1'b0;
		// previous sweep's last products are taken before this edge
		@(negedge clk);
		kernel0 = tab_kern[i][0];
		kernel1 = tab_kern[i][1];
		kernel2 = tab_kern[i][2];
		if (!tab_sweep[i]) begin
			repeat (40) begin
				@(negedge clk);
				if (busy) begin
					$display("entry %0d: busy rose before three rows were loaded", i);
					errors++;
				end
			end
			$display("entry %0d: row loaded, no sweep, %0d errors", i, errors - err_start);
		end else if (tab_intrude[i]) begin
			repeat (3) @(negedge clk);
			if (!busy) begin
				$display("entry %0d: busy was low when the extra row was offered", i);
				errors++;
			end
			row_data = random_row();
			row_valid = 1'b1;
			@(negedge clk);
			row_valid = 1'b0;
			$display("entry %0d: extra row offered while busy", i);
		end
	endtask

	task automatic drain_results();
		for (int n = 0; n < 200; n++) begin
			@(negedge clk);
			if (pending_q.size() == 0) begin
				// idle cycles to catch a stray out_valid
				repeat (10) @(negedge clk);
				return;
			end
		end
		$display("timeout: %0d sweeps still incomplete after 200 cycles", pending_q.size());
		timeout_hit = 1'b1;
	endtask

	// result checker, outputs are stable on the falling edge
	always @(negedge clk) begin
		int e;
		cyc = cyc + 1;
		if (busy && !busy_prev) begin
			busy_rise = cyc;
		end
		busy_prev = busy;
		if (rst_n && out_valid) begin
			if (pending_q.size() == 0) begin
				$display("out_valid at %0t ns with no sweep pending", $time);
				errors++;
			end else begin
				e = pending_q[0];
				if (mon_col == 0) begin
					sweep_err_start = errors;
					if (cyc - busy_rise != 3) begin
						$display("entry %0d: out_valid %0d cycles after busy rose, not 3",
							e, cyc - busy_rise);
						errors++;
					end
				end
				check_value("out_col", longint'(mon_col), longint'(out_col));
				check_value($sformatf("result0 col %0d", mon_col),
					exp_sum[e][mon_col][0], longint'(result0));
				check_value($sformatf("result1 col %0d", mon_col),
					exp_sum[e][mon_col][1], longint'(result1));
				check_value($sformatf("result2 col %0d", mon_col),
					exp_sum[e][mon_col][2], longint'(result2));
				mon_col++;
				if (mon_col == `N_COLS) begin
					$display("entry %0d: sweep of %0d windows, %0d errors",
						e, `N_COLS, errors - sweep_err_start);
					void'(pending_q.pop_front());
					mon_col = 0;
				end
			end
		end else if (rst_n && mon_col != 0) begin
			// a sweep's windows come out back to back
			$display("entry %0d: out_valid dropped after column %0d",
				pending_q[0], mon_col - 1);
			errors++;
		end
	end

	initial begin
		void'($urandom(32'hd9152361));
		rst_n = 1'b0;
		row_valid = 1'b0;
		row_data = '0;
		kernel0 = '0;
		kernel1 = '0;
		kernel2 = '0;
		build_table();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("busy", longint'(0), longint'(busy));
		check_value("out_valid", longint'(0), longint'(out_valid));
		$display("reset: busy and out_valid checked");
		for (int i = 0; i < N_ENTRIES; i++) begin
			if (!timeout_hit) begin
				apply_entry(i);
			end
		end
		if (!timeout_hit) begin
			drain_results();
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0 && !timeout_hit) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/conv_pe_properties.sv
`timescale 1ns/100ps
`default_nettype none

module conv_pe_properties
	import conv_pe_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic busy,
	input row_t row_new,
	input logic out_valid,
	input col_t out_col
);

	ctrl_state_t mode;
	logic [5:0] busy_run;

	assign mode = busy ? SWEEP : IDLE;

	// consecutive cycles spent sweeping
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_run <= '0;
		end else if (mode == SWEEP) begin
			busy_run <= busy_run + 6'd1;
		end else begin
			busy_run <= '0;
		end
	end

	assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && $past(out_valid)) |->
			((out_col == col_t'($past(out_col) + 5'd1)) || (out_col == '0)))
		else $error("out_col did not step by one");

	assert property (@(posedge clk) disable iff (!rst_n) busy_run <= 6'd30)
		else $error("busy high for more than 30 cycles");

	// no row enters the buffer during a sweep
	assert property (@(posedge clk) disable iff (!rst_n) busy |=> $stable(row_new))
		else $error("row buffer changed while busy");

endmodule

`default_nettype wire

// File: source/conv_pe_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv_pe_top
	import conv_pe_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    row_valid,
	input  row_t    row_data,
	input  kernel_t kernel0,
	input  kernel_t kernel1,
	input  kernel_t kernel2,
	output logic    busy,
	output logic    out_valid,
	output col_t    out_col,
	output acc_t    result0,
	output acc_t    result1,
	output acc_t    result2
);

	logic row_shift;
	logic sweep_valid;
	col_t sweep_col;
	row_t row_old;
	row_t row_mid;
	row_t row_new;

	window_if win_bus ();

	conv_pe_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.row_valid   (row_valid),
		.busy        (busy),
		.row_shift   (row_shift),
		.sweep_valid (sweep_valid),
		.sweep_col   (sweep_col)
	);

	line_buffer u_line_buffer (
		.clk       (clk),
		.rst_n     (rst_n),
		.row_shift (row_shift),
		.row_data  (row_data),
		.row_old   (row_old),
		.row_mid   (row_mid),
		.row_new   (row_new)
	);

	window_select u_window_select (
		.clk         (clk),
		.rst_n       (rst_n),
		.sweep_valid (sweep_valid),
		.sweep_col   (sweep_col),
		.row_old     (row_old),
		.row_mid     (row_mid),
		.row_new     (row_new),
		.win         (win_bus.src)
	);

	// three kernels share one window
	conv_mac_array u_mac_array (
		.win       (win_bus.dst),
		.clk       (clk),
		.rst_n     (rst_n),
		.kernel0   (kernel0),
		.kernel1   (kernel1),
		.kernel2   (kernel2),
		.out_valid (out_valid),
		.out_col   (out_col),
		.result0   (result0),
		.result1   (result1),
		.result2   (result2)
	);

endmodule

`default_nettype wire

// File: source/conv_mac_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_pe_params.svh"

module conv_mac_array
	import conv_pe_pkg::*;
(
	window_if.dst win,
	input  logic    clk,
	input  logic    rst_n,
	input  kernel_t kernel0,
	input  kernel_t kernel1,
	input  kernel_t kernel2,
	output logic    out_valid,
	output col_t    out_col,
	output acc_t    result0,
	output acc_t    result1,
	output acc_t    result2
);

	localparam int N_TAPS = `K_SIZE * `K_SIZE;

	typedef logic signed [2*`PIXEL_W-1:0] prod_t;

	pixel_t taps [N_TAPS];
	kernel_t kern [`N_KERNELS];
	prod_t prod_q [`N_KERNELS][N_TAPS];
	acc_t sum_d [`N_KERNELS];
	acc_t sum_q [`N_KERNELS];
	logic valid1_q;
	col_t col1_q;

	// flatten window in the same row-major order as the kernels
	always_comb begin
		for (int k = 0; k < `K_SIZE; k++) begin
			taps[k] = win.win_top[k];
			taps[`K_SIZE + k] = win.win_mid[k];
			taps[2*`K_SIZE + k] = win.win_bot[k];
		end
	end

	assign kern[0] = kernel0;
	assign kern[1] = kernel1;
	assign kern[2] = kernel2;

	// stage one: 27 products, weights sampled here
	always_ff @(posedge clk) begin
		if (win.win_valid) begin
			for (int n = 0; n < `N_KERNELS; n++) begin
				for (int i = 0; i < N_TAPS; i++) begin
					prod_q[n][i] <= taps[i] * kern[n][i];
				end
			end
			col1_q <= win.win_col;
		end
	end

	// stage two: full-width sums, no truncation
	always_comb begin
		for (int n = 0; n < `N_KERNELS; n++) begin
			sum_d[n] = '0;
			for (int i = 0; i < N_TAPS; i++) begin
				sum_d[n] = sum_d[n] + acc_t'(prod_q[n][i]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (valid1_q) begin
			for (int n = 0; n < `N_KERNELS; n++) begin
				sum_q[n] <= sum_d[n];
			end
			out_col <= col1_q;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid1_q <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			valid1_q <= win.win_valid;
			out_valid <= valid1_q;
		end
	end

	assign result0 = sum_q[0];
	assign result1 = sum_q[1];
	assign result2 = sum_q[2];

endmodule

`default_nettype wire

// File: source/window_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_pe_params.svh"

module window_select
	import conv_pe_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic sweep_valid,
	input  col_t sweep_col,
	input  row_t row_old,
	input  row_t row_mid,
	input  row_t row_new,
	window_if.src win
);

	tap_row_t top_d;
	tap_row_t mid_d;
	tap_row_t bot_d;

	// three adjacent pixels from sweep_col onwards
	always_comb begin
		for (int k = 0; k < `K_SIZE; k++) begin
			top_d[k] = row_old[int'(sweep_col) + k];
			mid_d[k] = row_mid[int'(sweep_col) + k];
			bot_d[k] = row_new[int'(sweep_col) + k];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win.win_valid <= 1'b0;
		end else begin
			win.win_valid <= sweep_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sweep_valid) begin
			win.win_top <= top_d;
			win.win_mid <= mid_d;
			win.win_bot <= bot_d;
			win.win_col <= sweep_col;
		end
	end

endmodule

`default_nettype wire

// File: source/line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module line_buffer
	import conv_pe_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic row_shift,
	input  row_t row_data,
	output row_t row_old,
	output row_t row_mid,
	output row_t row_new
);

	row_t old_q;
	row_t mid_q;
	row_t new_q;

	// oldest row falls out, incoming row lands in the newest slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			old_q <= '0;
			mid_q <= '0;
			new_q <= '0;
		end else if (row_shift) begin
			old_q <= mid_q;
			mid_q <= new_q;
			new_q <= row_data;
		end
	end

	assign row_old = old_q;
	assign row_mid = mid_q;
	assign row_new = new_q;

endmodule

`default_nettype wire

// File: source/conv_pe_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_pe_params.svh"

module conv_pe_ctrl
	import conv_pe_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic row_valid,
	output logic busy,
	output logic row_shift,
	output logic sweep_valid,
	output col_t sweep_col
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	logic [1:0] fill_q;
	col_t col_q;
	logic accept;
	logic start;
	logic last_col;

	assign busy = (state_q == SWEEP);

	// rows offered while sweeping are dropped
	assign accept = row_valid && !busy;

	// a sweep needs three rows in the buffer, counting this one
	assign start = accept && (fill_q >= 2'd2);

	assign last_col = (col_q == col_t'(`N_COLS - 1));

	assign row_shift = accept;
	assign sweep_valid = busy;
	assign sweep_col = col_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start) begin
					state_d = SWEEP;
				end
			end
			SWEEP: begin
				if (last_col) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// fill count saturates once the buffer is full
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fill_q <= 2'd0;
		end else if (accept && (fill_q != 2'(`K_SIZE))) begin
			fill_q <= fill_q + 2'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_q <= '0;
		end else if (start) begin
			col_q <= '0;
		end else if (busy) begin
			col_q <= col_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/window_if.sv
`timescale 1ns/100ps
`default_nettype none

interface window_if
	import conv_pe_pkg::*;
();
	// oldest row on top
	tap_row_t win_top;
	tap_row_t win_mid;
	tap_row_t win_bot;
	col_t win_col;
	logic win_valid;

	modport src (
		output win_top, win_mid, win_bot,
		output win_col, win_valid
	);

	modport dst (
		input win_top, win_mid, win_bot,
		input win_col, win_valid
	);

endinterface

`default_nettype wire

// File: source/conv_pe_pkg.sv
`default_nettype none

package conv_pe_pkg;

`include "conv_pe_params.svh"

	typedef logic signed [`PIXEL_W-1:0] pixel_t;
	typedef logic signed [`PIXEL_W-1:0] weight_t;

	// element 0 is the leftmost pixel
	typedef pixel_t [`ROW_LEN-1:0] row_t;
	typedef pixel_t [`K_SIZE-1:0] tap_row_t;

	// row-major, index r*3+k with r=0 the oldest row
	typedef weight_t [`K_SIZE*`K_SIZE-1:0] kernel_t;

	typedef logic signed [`ACC_W-1:0] acc_t;
	typedef logic [`COL_W-1:0] col_t;

	typedef enum logic {
		IDLE,
		SWEEP
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: include/conv_pe_params.svh
`ifndef CONV_PE_PARAMS_SVH
`define CONV_PE_PARAMS_SVH

// pixel and weight width
`define PIXEL_W 9

// image row and kernel geometry
`define ROW_LEN 32
`define K_SIZE 3
`define N_KERNELS 3
`define N_COLS (`ROW_LEN - `K_SIZE + 1)

// column index, 0 to N_COLS-1
`define COL_W 5

// 18-bit product plus growth for 9 terms
`define ACC_W 22

`endif
